// File: src/rs_pkg.sv
package rs_pkg;

    // Widths shared by every block of the issue subsystem
    localparam int rob_id_w = 6;
    localparam int data_w   = 32;

    typedef logic [rob_id_w-1:0] t_robid;
    typedef logic [data_w-1:0]   t_data;

    // ALU operations carried by a micro-op
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6
    } t_opcode;

    // One source as it arrives with dispatch
    // value only means something when from_rob is low
    typedef struct packed {
        logic   from_rob;
        t_robid robid;
        t_data  value;
    } t_src_disp;

    // Micro-op at dispatch
    typedef struct packed {
        t_opcode   opcode;
        t_robid    robid;
        t_src_disp src1;
        t_src_disp src2;
    } t_uinstr_disp;

    // Result broadcast, valid only, never stalled
    typedef struct packed {
        logic   valid;
        t_robid robid;
        t_data  data;
    } t_rob_result;

    // Micro-op leaving an entry with both operands resolved
    typedef struct packed {
        t_opcode opcode;
        t_robid  robid;
        t_data   src1_val;
        t_data   src2_val;
    } t_uinstr_iss;

    // Reservation station entry state
    typedef enum logic {
        IDLE,
        VALID
    } t_rs_ent_fsm;

endpackage

// File: src/rs_reg_trk.sv
`timescale 1ns/1ps

module rs_reg_trk (
    input  logic                clk,
    input  logic                reset,

    input  logic                alloc,
    input  rs_pkg::t_src_disp   alloc_src,

    input  rs_pkg::t_rob_result ext_result,
    input  rs_pkg::t_rob_result alu_result,

    output logic                ready,
    output rs_pkg::t_data       src_data
);

    logic           pending;
    rs_pkg::t_robid wait_robid;
    rs_pkg::t_data  value;

    rs_pkg::t_robid match_robid;
    logic           watching;
    logic           ext_hit;
    logic           alu_hit;

    // On allocation compare against the incoming source for bypass
    assign match_robid = alloc ? alloc_src.robid : wait_robid;
    assign watching    = alloc ? alloc_src.from_rob : pending;

    assign ext_hit = watching && ext_result.valid && (ext_result.robid == match_robid);
    assign alu_hit = watching && alu_result.valid && (alu_result.robid == match_robid);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (alloc) begin
            pending <= alloc_src.from_rob && !ext_hit && !alu_hit;
        end else if (ext_hit || alu_hit) begin
            pending <= 1'b0;
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            wait_robid <= alloc_src.robid;
        end
        if (ext_hit) begin
            value <= ext_result.data;
        end else if (alu_hit) begin
            value <= alu_result.data;
        end else if (alloc) begin
            value <= alloc_src.value;
        end
    end

    assign ready    = !pending;
    assign src_data = value;

    // Producer ids are unique across both result buses
    a_single_bus_hit: assert property (@(posedge clk) disable iff (reset)
        ext_hit |-> !alu_hit)
        else $error("rs_reg_trk: both result buses match robid %0d", match_robid);

endmodule

// File: src/rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 alloc,
    input  rs_pkg::t_uinstr_disp alloc_uinstr,

    input  rs_pkg::t_rob_result  ext_result,
    input  rs_pkg::t_rob_result  alu_result,

    output logic                 valid,
    output logic                 req_issue,
    output rs_pkg::t_uinstr_iss  issue_pkt,
    input  logic                 gnt_issue
);

    localparam int src1_idx    = 0;
    localparam int src2_idx    = 1;
    localparam int num_sources = 2;

    rs_pkg::t_rs_ent_fsm fsm;
    rs_pkg::t_rs_ent_fsm fsm_nxt;

    rs_pkg::t_opcode     opcode;
    rs_pkg::t_robid      robid;

    rs_pkg::t_src_disp       alloc_srcs [num_sources];
    logic [num_sources-1:0]  src_ready;
    rs_pkg::t_data           src_data   [num_sources];

    // Entry lifetime
    always_comb begin
        fsm_nxt = fsm;
        unique case (fsm)
            rs_pkg::IDLE: begin
                if (alloc) begin
                    fsm_nxt = rs_pkg::VALID;
                end
            end
            rs_pkg::VALID: begin
                // Only a grant frees an entry for now
                if (gnt_issue) begin
                    fsm_nxt = rs_pkg::IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fsm <= rs_pkg::IDLE;
        end else begin
            fsm <= fsm_nxt;
        end
    end

    assign valid = (fsm == rs_pkg::VALID);

    // Static part of the micro-op
    always_ff @(posedge clk) begin
        if (alloc) begin
            opcode <= alloc_uinstr.opcode;
            robid  <= alloc_uinstr.robid;
        end
    end

    assign alloc_srcs[src1_idx] = alloc_uinstr.src1;
    assign alloc_srcs[src2_idx] = alloc_uinstr.src2;

    for (genvar srcx = 0; srcx < num_sources; srcx++) begin : g_src_trk
        rs_reg_trk rs_reg_trk_inst (
            .clk        (clk),
            .reset      (reset),
            .alloc      (alloc),
            .alloc_src  (alloc_srcs[srcx]),
            .ext_result (ext_result),
            .alu_result (alu_result),
            .ready      (src_ready[srcx]),
            .src_data   (src_data[srcx])
        );
    end

    assign req_issue = valid && (&src_ready);

    always_comb begin
        issue_pkt.opcode   = opcode;
        issue_pkt.robid    = robid;
        issue_pkt.src1_val = src_data[src1_idx];
        issue_pkt.src2_val = src_data[src2_idx];
    end

    // Picker must only fill free entries
    a_alloc_idle: assert property (@(posedge clk) disable iff (reset)
        alloc |-> (fsm == rs_pkg::IDLE))
        else $error("rs_entry: allocation into a busy entry");

    // Grant without a request would issue stale operands
    a_gnt_req: assert property (@(posedge clk) disable iff (reset)
        gnt_issue |-> req_issue)
        else $error("rs_entry: grant without issue request");

endmodule

// File: src/rs_picker.sv
`timescale 1ns/1ps

module rs_picker #(
    parameter int num_entries = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [num_entries-1:0]  entry_valid,
    input  logic [num_entries-1:0]  req_issue,
    input  rs_pkg::t_uinstr_iss     issue_pkts [num_entries],

    input  logic                    disp_valid,
    output logic                    disp_ready,
    output logic [num_entries-1:0]  alloc_onehot,

    output logic [num_entries-1:0]  gnt_issue,
    output logic                    iss_valid,
    output rs_pkg::t_uinstr_iss     iss_pkt
);

    logic [num_entries-1:0] free_vec;
    logic [num_entries-1:0] free_first;
    logic                   disp_fire;

    // Allocation side
    assign free_vec = ~entry_valid;

    // Isolate the lowest set bit
    assign free_first = free_vec & (~free_vec + 1'b1);

    assign disp_ready = |free_vec;
    assign disp_fire  = disp_valid && disp_ready;

    assign alloc_onehot = disp_fire ? free_first : '0;

    // Issue side, fixed priority toward entry 0
    assign gnt_issue = req_issue & (~req_issue + 1'b1);
    assign iss_valid = |req_issue;

    always_comb begin
        iss_pkt = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (gnt_issue[i]) begin
                iss_pkt = issue_pkts[i];
            end
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(gnt_issue))
        else $error("rs_picker: more than one issue grant");

    a_alloc_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(alloc_onehot))
        else $error("rs_picker: more than one entry allocated");

endmodule

// File: src/rs_exec_alu.sv
`timescale 1ns/1ps

module rs_exec_alu (
    input  logic                clk,
    input  logic                reset,

    input  logic                iss_valid,
    input  rs_pkg::t_uinstr_iss iss_pkt,

    output rs_pkg::t_rob_result alu_result
);

    rs_pkg::t_data  result_ex0;
    logic [4:0]     shamt;

    logic           res_valid;
    rs_pkg::t_robid res_robid;
    rs_pkg::t_data  res_data;

    assign shamt = iss_pkt.src2_val[4:0];

    always_comb begin
        unique case (iss_pkt.opcode)
            rs_pkg::ADD: begin
                result_ex0 = iss_pkt.src1_val + iss_pkt.src2_val;
            end
            rs_pkg::SUB: begin
                result_ex0 = iss_pkt.src1_val - iss_pkt.src2_val;
            end
            rs_pkg::AND: begin
                result_ex0 = iss_pkt.src1_val & iss_pkt.src2_val;
            end
            rs_pkg::OR: begin
                result_ex0 = iss_pkt.src1_val | iss_pkt.src2_val;
            end
            rs_pkg::XOR: begin
                result_ex0 = iss_pkt.src1_val ^ iss_pkt.src2_val;
            end
            rs_pkg::SLL: begin
                result_ex0 = iss_pkt.src1_val << shamt;
            end
            rs_pkg::SRL: begin
                result_ex0 = iss_pkt.src1_val >> shamt;
            end
            default: begin
                result_ex0 = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res_robid <= iss_pkt.robid;
            res_data  <= result_ex0;
        end
    end

    assign alu_result = '{valid: res_valid, robid: res_robid, data: res_data};

    a_legal_opcode: assert property (@(posedge clk) disable iff (reset)
        iss_valid |-> (iss_pkt.opcode inside {rs_pkg::ADD, rs_pkg::SUB, rs_pkg::AND,
            rs_pkg::OR, rs_pkg::XOR, rs_pkg::SLL, rs_pkg::SRL}))
        else $error("rs_exec_alu: illegal opcode %0d", iss_pkt.opcode);

endmodule

// File: src/rs_top.sv
`timescale 1ns/1ps

module rs_top #(
    parameter int num_entries = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 disp_valid,
    input  rs_pkg::t_uinstr_disp disp_uinstr,
    output logic                 disp_ready,

    input  rs_pkg::t_rob_result  ext_result,
    output rs_pkg::t_rob_result  result_out
);

    logic [num_entries-1:0] entry_valid;
    logic [num_entries-1:0] alloc_onehot;
    logic [num_entries-1:0] req_issue;
    logic [num_entries-1:0] gnt_issue;
    rs_pkg::t_uinstr_iss    issue_pkts [num_entries];

    logic                   iss_valid;
    rs_pkg::t_uinstr_iss    iss_pkt;

    // ALU result wakes up local entries and leaves the subsystem
    rs_pkg::t_rob_result    alu_result;

    rs_picker #(
        .num_entries (num_entries)
    ) rs_picker_inst (
        .clk          (clk),
        .reset        (reset),
        .entry_valid  (entry_valid),
        .req_issue    (req_issue),
        .issue_pkts   (issue_pkts),
        .disp_valid   (disp_valid),
        .disp_ready   (disp_ready),
        .alloc_onehot (alloc_onehot),
        .gnt_issue    (gnt_issue),
        .iss_valid    (iss_valid),
        .iss_pkt      (iss_pkt)
    );

    for (genvar e = 0; e < num_entries; e++) begin : g_entry
        rs_entry rs_entry_inst (
            .clk          (clk),
            .reset        (reset),
            .alloc        (alloc_onehot[e]),
            .alloc_uinstr (disp_uinstr),
            .ext_result   (ext_result),
            .alu_result   (alu_result),
            .valid        (entry_valid[e]),
            .req_issue    (req_issue[e]),
            .issue_pkt    (issue_pkts[e]),
            .gnt_issue    (gnt_issue[e])
        );
    end

    rs_exec_alu rs_exec_alu_inst (
        .clk        (clk),
        .reset      (reset),
        .iss_valid  (iss_valid),
        .iss_pkt    (iss_pkt),
        .alu_result (alu_result)
    );

    assign result_out = alu_result;

endmodule

// File: dv/rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

    localparam int num_entries  = 4;
    localparam int num_uops     = 400;
    localparam int cyc_per_uop  = 60;
    localparam int reset_cycles = 8;
    localparam int alu_ids      = 32;
    localparam int max_ext_wait = 40;
    localparam int drain_limit  = 500;

    logic                 clk;
    logic                 reset;
    logic                 disp_valid;
    rs_pkg::t_uinstr_disp disp_uinstr;
    logic                 disp_ready;
    rs_pkg::t_rob_result  ext_result;
    rs_pkg::t_rob_result  result_out;

    // ALU ids 0..31, external ids 32..63
    // uop_state 0 free, 1 held at the dispatch port, 2 inside the DUT
    int              uop_state [64];
    rs_pkg::t_opcode uop_op    [64];
    logic            src_pend  [64][2];
    rs_pkg::t_robid  src_ref   [64][2];
    rs_pkg::t_data   src_val   [64][2];
    logic            ext_live  [64];
    int              ext_wait  [64];
    rs_pkg::t_data   ext_data  [64];

    logic [31:0]          rng;
    int                   held_id;
    int                   created;
    int                   dispatched;
    int                   results;
    int                   occupancy;
    int                   full_cycles;
    int                   bypasses;
    int                   drain_cycles;
    int                   checks;
    int                   errors;
    logic                 nxt_valid;
    rs_pkg::t_uinstr_disp nxt_uinstr;
    rs_pkg::t_rob_result  nxt_ext;

    rs_top #(
        .num_entries (num_entries)
    ) rs_top_inst (
        .clk         (clk),
        .reset       (reset),
        .disp_valid  (disp_valid),
        .disp_uinstr (disp_uinstr),
        .disp_ready  (disp_ready),
        .ext_result  (ext_result),
        .result_out  (result_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand32() % n);
    endfunction

    function automatic rs_pkg::t_data alu_model(input rs_pkg::t_opcode op,
                                                input rs_pkg::t_data a,
                                                input rs_pkg::t_data b);
        case (op)
            rs_pkg::ADD: return a + b;
            rs_pkg::SUB: return a - b;
            rs_pkg::AND: return a & b;
            rs_pkg::OR:  return a | b;
            rs_pkg::XOR: return a ^ b;
            rs_pkg::SLL: return a << b[4:0];
            default:     return a >> b[4:0];
        endcase
    endfunction

    // Kind 0 free ALU id, 1 producer inside the DUT, 2 free external id
    function automatic int find_slot(input int kind);
        int start;
        int id;
        start = rand_below(alu_ids);
        for (int k = 0; k < alu_ids; k++) begin
            id = (start + k) % alu_ids;
            if (kind == 0 && uop_state[id] == 0) return id;
            if (kind == 1 && uop_state[id] == 2) return id;
            if (kind == 2 && !ext_live[id + alu_ids]) return id + alu_ids;
        end
        return -1;
    endfunction

    function automatic rs_pkg::t_uinstr_disp disp_packet(input int id);
        rs_pkg::t_uinstr_disp p;
        p.opcode = uop_op[id];
        p.robid  = rs_pkg::t_robid'(id);
        p.src1   = '{from_rob: src_pend[id][0], robid: src_ref[id][0], value: src_val[id][0]};
        p.src2   = '{from_rob: src_pend[id][1], robid: src_ref[id][1], value: src_val[id][1]};
        return p;
    endfunction

    task automatic new_uop();
        int id;
        int slot;
        id = find_slot(0);
        if (id < 0) return;
        uop_state[id] = 1;
        uop_op[id]    = rs_pkg::t_opcode'(rand_below(7));
        for (int s = 0; s < 2; s++) begin
            // A pending source carries garbage in its value field
            src_pend[id][s] = 1'b0;
            src_val[id][s]  = rand32();
            src_ref[id][s]  = '0;
            case (rand_below(3))
                1:       slot = find_slot(1);
                2:       slot = find_slot(2);
                default: slot = -1;
            endcase
            if (slot >= alu_ids) begin
                ext_live[slot] = 1'b1;
                ext_wait[slot] = 1 + rand_below(max_ext_wait);
                ext_data[slot] = rand32();
            end
            if (slot >= 0) begin
                src_pend[id][s] = 1'b1;
                src_ref[id][s]  = rs_pkg::t_robid'(slot);
            end
        end
        held_id = id;
        created++;
    endtask

    // Wakes every model source waiting on robid r
    task automatic resolve(input rs_pkg::t_robid r, input rs_pkg::t_data v);
        for (int id = 0; id < alu_ids; id++) begin
            for (int s = 0; s < 2; s++) begin
                if (uop_state[id] != 0 && src_pend[id][s] && src_ref[id][s] == r) begin
                    src_pend[id][s] = 1'b0;
                    src_val[id][s]  = v;
                end
            end
        end
    endtask

    task automatic check_result(input int rid);
        rs_pkg::t_data expected;
        logic          in_flight;
        in_flight = (rid < alu_ids) && (uop_state[rid] == 2);
        assert (in_flight) else begin
            errors++;
            $display("%0t: result_out carries robid %0d, which is not in flight", $time, rid);
        end
        if (in_flight) begin
            assert (!src_pend[rid][0] && !src_pend[rid][1]) else begin
                errors++;
                $display("%0t: robid %0d produced a result before its operands arrived",
                         $time, rid);
            end
            expected = alu_model(uop_op[rid], src_val[rid][0], src_val[rid][1]);
            checks++;
            assert (result_out.data == expected) else begin
                errors++;
                $display("Mismatch at %0t: result_out.data robid %0d got %h expected %h",
                         $time, rid, result_out.data, expected);
            end
            resolve(rs_pkg::t_robid'(rid), expected);
            uop_state[rid] = 0;
            results++;
            occupancy--;
        end
    endtask

    // Work done at every rising edge after reset
    task automatic step();
        logic accept;
        int   acc_id;
        logic was_pend [2];
        accept = disp_valid && disp_ready;
        acc_id = held_id;
        if (accept) begin
            uop_state[acc_id] = 2;
            dispatched++;
            held_id     = -1;
            was_pend[0] = src_pend[acc_id][0];
            was_pend[1] = src_pend[acc_id][1];
        end
        if (result_out.valid) check_result(int'(result_out.robid));
        if (ext_result.valid) begin
            resolve(ext_result.robid, ext_result.data);
            ext_live[ext_result.robid] = 1'b0;
        end
        for (int s = 0; s < 2; s++) begin
            if (accept && was_pend[s] && !src_pend[acc_id][s]) bypasses++;
        end
        // Occupancy here counts grants up to the previous edge
        checks++;
        assert (disp_ready == (occupancy < num_entries)) else begin
            errors++;
            $display("Mismatch at %0t: disp_ready got %b expected %b",
                     $time, disp_ready, occupancy < num_entries);
        end
        if (!disp_ready) full_cycles++;
        if (accept) occupancy++;
        nxt_ext = '0;
        for (int id = 63; id >= alu_ids; id--) begin
            if (ext_live[id] && ext_wait[id] > 0) ext_wait[id]--;
            if (ext_live[id] && ext_wait[id] == 0) begin
                nxt_ext = '{valid: 1'b1, robid: rs_pkg::t_robid'(id), data: ext_data[id]};
            end
        end
        if (held_id < 0 && created < num_uops && rand_below(4) != 0) new_uop();
        nxt_valid  = (held_id >= 0);
        nxt_uinstr = '0;
        if (held_id >= 0) nxt_uinstr = disp_packet(held_id);
    endtask

    initial begin
        rng          = 32'h5b68984e;
        held_id      = -1;
        created      = 0;
        dispatched   = 0;
        results      = 0;
        occupancy    = 0;
        full_cycles  = 0;
        bypasses     = 0;
        drain_cycles = 0;
        checks       = 0;
        errors       = 0;
        for (int id = 0; id < 64; id++) begin
            uop_state[id] = 0;
            ext_live[id]  = 1'b0;
        end
        reset       = 1'b1;
        disp_valid  = 1'b0;
        disp_uinstr = '0;
        ext_result  = '0;
        $display("Seed %h", rng);
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        checks++;
        assert (disp_ready && !result_out.valid) else begin
            errors++;
            $display("%0t: after reset disp_ready is low or result_out is valid", $time);
        end
        while (results < num_uops && drain_cycles < drain_limit) begin
            step();
            disp_valid  <= nxt_valid;
            disp_uinstr <= nxt_uinstr;
            ext_result  <= nxt_ext;
            if (dispatched == num_uops) drain_cycles++;
            @(posedge clk);
        end
        for (int id = 0; id < alu_ids; id++) begin
            assert (uop_state[id] != 2) else begin
                errors++;
                $display("Micro-op with robid %0d was dispatched but produced no result", id);
            end
        end
        assert (full_cycles > 0) else begin
            errors++;
            $display("Dispatch never stalled, the entries were never all in use");
        end
        assert (bypasses > 0) else begin
            errors++;
            $display("No micro-op was dispatched in the cycle its operand was broadcast");
        end
        $display("Checks %0d, errors %0d, results %0d of %0d, bypasses %0d, full cycles %0d",
                 checks, errors, results, num_uops, bypasses, full_cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (reset_cycles + num_uops * cyc_per_uop) @(posedge clk);
        $display("Timeout with %0d of %0d results seen, errors %0d",
                 results, num_uops, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: compile.f
src/rs_pkg.sv
src/rs_reg_trk.sv
src/rs_entry.sv
src/rs_picker.sv
src/rs_exec_alu.sv
src/rs_top.sv
dv/rs_tb.sv

// File: Makefile
TOP       ?= rs_tb
VERILATOR ?= verilator
LOG       ?= sim.log
SEED_LOG  ?= seed.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR), $(LOG) and $(SEED_LOG)"
	@echo "Variables: TOP VERILATOR LOG SEED_LOG OBJ_DIR FILELIST"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep "^Seed" $(LOG) > $(SEED_LOG) || true
	@grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG) $(SEED_LOG)
